//--- verilog/cpu_types_pkg.sv
// shared types for the ex/mem slice; RAM_WAIT must be at least 1 and RAM_WORDS a power of two
package cpu_types_pkg;

    // --------------------------------------------------
    // words and fields
    // --------------------------------------------------
    typedef logic [31:0] word_t;     // data, address or instruction
    typedef logic [4:0]  regbits_t;  // register write select
    typedef logic [4:0]  shamt_t;    // shift amount

    localparam regbits_t REG_RA = 5'd31;  // jal link register

    // --------------------------------------------------
    // alu operations
    // --------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,   // signed compare
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,   // shifts act on operand b by shamt
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10
    } aluop_t;

    // --------------------------------------------------
    // data memory
    // --------------------------------------------------
    localparam int unsigned RAM_WORDS = 256;
    typedef logic [$clog2(RAM_WORDS)-1:0] ramaddr_t;  // word index

    // cycles a request waits before the hit cycle
    localparam int unsigned RAM_WAIT   = 2;
    localparam int unsigned RAM_WAIT_W = $clog2(RAM_WAIT + 1);

endpackage

//--- verilog/execute_stage.sv
// combinational execute stage; shifts use operand b, zero comes from the raw alu result
module execute_stage (
    input  cpu_types_pkg::aluop_t   aluop,
    input  cpu_types_pkg::word_t    rdat1,
    input  cpu_types_pkg::word_t    rdat2,
    input  cpu_types_pkg::word_t    ext_imm,
    input  cpu_types_pkg::word_t    pcplusfour,
    input  cpu_types_pkg::shamt_t   shamt,
    input  cpu_types_pkg::word_t    j_addr,
    input  logic                    alusrc,
    input  logic                    lui,
    input  logic                    jal,
    input  cpu_types_pkg::regbits_t wsel,
    output cpu_types_pkg::word_t    alu_out,
    output logic                    zero,
    output cpu_types_pkg::word_t    branch_addr,
    output cpu_types_pkg::word_t    jump_addr,
    output cpu_types_pkg::regbits_t wsel_out
);

    cpu_types_pkg::word_t opa;
    cpu_types_pkg::word_t opb;
    cpu_types_pkg::word_t alu_res;  // before lui / jal override

    assign opa = rdat1;
    assign opb = alusrc ? ext_imm : rdat2;

    // --------------------------------------------------
    // alu
    // --------------------------------------------------
    always_comb begin
        alu_res = '0;
        case (aluop)
            cpu_types_pkg::ALU_ADD: begin
                alu_res = opa + opb;
            end
            cpu_types_pkg::ALU_SUB: begin
                alu_res = opa - opb;
            end
            cpu_types_pkg::ALU_AND: begin
                alu_res = opa & opb;
            end
            cpu_types_pkg::ALU_OR: begin
                alu_res = opa | opb;
            end
            cpu_types_pkg::ALU_XOR: begin
                alu_res = opa ^ opb;
            end
            cpu_types_pkg::ALU_NOR: begin
                alu_res = ~(opa | opb);
            end
            cpu_types_pkg::ALU_SLT: begin
                alu_res = {31'd0, $signed(opa) < $signed(opb)};
            end
            cpu_types_pkg::ALU_SLTU: begin
                alu_res = {31'd0, opa < opb};
            end
            cpu_types_pkg::ALU_SLL: begin
                alu_res = opb << shamt;
            end
            cpu_types_pkg::ALU_SRL: begin
                alu_res = opb >> shamt;
            end
            cpu_types_pkg::ALU_SRA: begin
                alu_res = $signed(opb) >>> shamt;
            end
            default: begin
                alu_res = '0;  // unused encodings
            end
        endcase
    end

    // branches issue a sub, so this is rdat1 == rdat2 for them
    assign zero = (alu_res == '0);

    always_comb begin
        if (jal) begin
            alu_out = pcplusfour;  // link value
        end else if (lui) begin
            alu_out = {ext_imm[15:0], 16'h0000};
        end else begin
            alu_out = alu_res;
        end
    end

    // --------------------------------------------------
    // redirect targets
    // --------------------------------------------------
    assign branch_addr = pcplusfour + (ext_imm << 2);
    assign jump_addr   = {pcplusfour[31:28], j_addr[25:0], 2'b00};

    assign wsel_out = jal ? cpu_types_pkg::REG_RA : wsel;

endmodule

//--- verilog/ex_mem_latch.sv
// ex/mem register; upstream must hold its values while stall is high
module ex_mem_latch (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    stall,
    input  logic                    dren,
    input  logic                    dwen,
    input  logic                    regwr,
    input  logic                    memtoreg,
    input  logic                    beq,
    input  logic                    bne,
    input  logic                    jump,
    input  logic                    jr,
    input  logic                    halt,
    input  logic                    zero,
    input  cpu_types_pkg::word_t    alu_out,
    input  cpu_types_pkg::word_t    rdat1,
    input  cpu_types_pkg::word_t    rdat2,
    input  cpu_types_pkg::word_t    branch_addr,
    input  cpu_types_pkg::word_t    jump_addr,
    input  cpu_types_pkg::regbits_t wsel,
    output logic                    dren_out,
    output logic                    dwen_out,
    output logic                    regwr_out,
    output logic                    memtoreg_out,
    output logic                    beq_out,
    output logic                    bne_out,
    output logic                    jump_out,
    output logic                    jr_out,
    output logic                    halt_out,
    output logic                    zero_out,
    output cpu_types_pkg::word_t    alu_out_out,
    output cpu_types_pkg::word_t    rdat1_out,
    output cpu_types_pkg::word_t    rdat2_out,
    output cpu_types_pkg::word_t    branch_addr_out,
    output cpu_types_pkg::word_t    jump_addr_out,
    output cpu_types_pkg::regbits_t wsel_out
);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            dren_out        <= 1'b0;
            dwen_out        <= 1'b0;
            regwr_out       <= 1'b0;
            memtoreg_out    <= 1'b0;
            beq_out         <= 1'b0;
            bne_out         <= 1'b0;
            jump_out        <= 1'b0;
            jr_out          <= 1'b0;
            halt_out        <= 1'b0;
            zero_out        <= 1'b0;
            alu_out_out     <= '0;
            rdat1_out       <= '0;
            rdat2_out       <= '0;
            branch_addr_out <= '0;
            jump_addr_out   <= '0;
            wsel_out        <= '0;
        end else if (!stall) begin  // hold everything while memory waits
            dren_out        <= dren;
            dwen_out        <= dwen;
            regwr_out       <= regwr;
            memtoreg_out    <= memtoreg;
            beq_out         <= beq;
            bne_out         <= bne;
            jump_out        <= jump;
            jr_out          <= jr;
            halt_out        <= halt;
            zero_out        <= zero;
            alu_out_out     <= alu_out;
            rdat1_out       <= rdat1;
            rdat2_out       <= rdat2;
            branch_addr_out <= branch_addr;
            jump_addr_out   <= jump_addr;
            wsel_out        <= wsel;
        end
    end

endmodule

//--- verilog/mem_stage.sv
// memory stage logic; outputs are meaningful only while stall is low
module mem_stage (
    input  logic                    dren,
    input  logic                    dwen,
    input  logic                    regwr,
    input  logic                    memtoreg,
    input  logic                    beq,
    input  logic                    bne,
    input  logic                    jump,
    input  logic                    jr,
    input  logic                    zero,
    input  logic                    halt,
    input  cpu_types_pkg::word_t    alu_out,
    input  cpu_types_pkg::word_t    rdat1,
    input  cpu_types_pkg::word_t    rdat2,
    input  cpu_types_pkg::word_t    branch_addr,
    input  cpu_types_pkg::word_t    jump_addr,
    input  cpu_types_pkg::regbits_t wsel,
    input  logic                    dhit,
    input  cpu_types_pkg::word_t    ram_rdata,
    output logic                    ram_ren,
    output logic                    ram_wen,
    output cpu_types_pkg::ramaddr_t ram_addr,
    output cpu_types_pkg::word_t    ram_wdata,
    output logic                    stall,
    output logic                    wb_regwr,
    output cpu_types_pkg::regbits_t wb_wsel,
    output cpu_types_pkg::word_t    wb_data,
    output logic                    redirect,
    output cpu_types_pkg::word_t    redirect_addr,
    output logic                    halt_out
);

    // --------------------------------------------------
    // data memory side
    // --------------------------------------------------
    assign ram_ren   = dren;
    assign ram_wen   = dwen;
    assign ram_addr  = alu_out[2 +: $bits(cpu_types_pkg::ramaddr_t)];  // byte to word
    assign ram_wdata = rdat2;

    assign stall = (dren | dwen) & ~dhit;

    // writeback
    assign wb_regwr = regwr & ~stall;
    assign wb_wsel  = wsel;
    assign wb_data  = memtoreg ? ram_rdata : alu_out;

    // --------------------------------------------------
    // pc redirect
    // --------------------------------------------------
    assign redirect = (beq & zero) | (bne & ~zero) | jump | jr;

    always_comb begin
        if (jr) begin
            redirect_addr = rdat1;
        end else if (jump) begin
            redirect_addr = jump_addr;
        end else begin
            redirect_addr = branch_addr;
        end
    end

    assign halt_out = halt;

endmodule

//--- verilog/data_ram.sv
// word RAM with RAM_WAIT idle cycles then a registered hit; request must stay high until dhit
module data_ram (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    ren,
    input  logic                    wen,
    input  cpu_types_pkg::ramaddr_t addr,
    input  cpu_types_pkg::word_t    wdata,
    output cpu_types_pkg::word_t    rdata,
    output logic                    dhit
);

    cpu_types_pkg::word_t mem [cpu_types_pkg::RAM_WORDS] = '{default: '0};

    logic [cpu_types_pkg::RAM_WAIT_W-1:0] wait_cnt;
    logic                                 req;
    logic                                 last_wait;

    assign req       = ren | wen;
    assign last_wait = (wait_cnt == cpu_types_pkg::RAM_WAIT_W'(cpu_types_pkg::RAM_WAIT));

    // --------------------------------------------------
    // wait counter and hit pulse
    // --------------------------------------------------
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
            dhit     <= 1'b0;
        end else begin
            dhit <= 1'b0;
            if (!req || dhit) begin
                wait_cnt <= '0;  // restart for a back to back request
            end else if (last_wait) begin
                dhit <= 1'b1;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // read data lands with dhit
    always_ff @(posedge CLK) begin
        if (req && last_wait && !dhit) begin
            rdata <= mem[addr];
        end
    end

    always_ff @(posedge CLK) begin
        if (wen && dhit) begin
            mem[addr] <= wdata;  // write in the hit cycle
        end
    end

endmodule

//--- verilog/exec_mem_top.sv
// execute + memory slice; upstream holds inputs while stall is high, no forwarding or flush
module exec_mem_top (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    dren,
    input  logic                    dwen,
    input  logic                    regwr,
    input  logic                    memtoreg,
    input  logic                    beq,
    input  logic                    bne,
    input  logic                    jump,
    input  logic                    jr,
    input  logic                    jal,
    input  logic                    lui,
    input  logic                    alusrc,
    input  logic                    halt,
    input  cpu_types_pkg::aluop_t   aluop,
    input  cpu_types_pkg::word_t    rdat1,
    input  cpu_types_pkg::word_t    rdat2,
    input  cpu_types_pkg::word_t    ext_imm,
    input  cpu_types_pkg::shamt_t   shamt,
    input  cpu_types_pkg::word_t    pcplusfour,
    input  cpu_types_pkg::word_t    j_addr,
    input  cpu_types_pkg::regbits_t wsel,
    output logic                    stall,
    output logic                    wb_regwr,
    output cpu_types_pkg::regbits_t wb_wsel,
    output cpu_types_pkg::word_t    wb_data,
    output logic                    redirect,
    output cpu_types_pkg::word_t    redirect_addr,
    output logic                    halt_out
);

    // execute results
    cpu_types_pkg::word_t    ex_alu_out;
    logic                    ex_zero;
    cpu_types_pkg::word_t    ex_branch_addr;
    cpu_types_pkg::word_t    ex_jump_addr;
    cpu_types_pkg::regbits_t ex_wsel;

    // latched fields
    logic                    mem_dren;
    logic                    mem_dwen;
    logic                    mem_regwr;
    logic                    mem_memtoreg;
    logic                    mem_beq;
    logic                    mem_bne;
    logic                    mem_jump;
    logic                    mem_jr;
    logic                    mem_halt;
    logic                    mem_zero;
    cpu_types_pkg::word_t    mem_alu_out;
    cpu_types_pkg::word_t    mem_rdat1;
    cpu_types_pkg::word_t    mem_rdat2;
    cpu_types_pkg::word_t    mem_branch_addr;
    cpu_types_pkg::word_t    mem_jump_addr;
    cpu_types_pkg::regbits_t mem_wsel;

    // ram side
    logic                    ram_ren;
    logic                    ram_wen;
    cpu_types_pkg::ramaddr_t ram_addr;
    cpu_types_pkg::word_t    ram_wdata;
    cpu_types_pkg::word_t    ram_rdata;
    logic                    dhit;

    execute_stage u_execute (
        .aluop       (aluop),
        .rdat1       (rdat1),
        .rdat2       (rdat2),
        .ext_imm     (ext_imm),
        .pcplusfour  (pcplusfour),
        .shamt       (shamt),
        .j_addr      (j_addr),
        .alusrc      (alusrc),
        .lui         (lui),
        .jal         (jal),
        .wsel        (wsel),
        .alu_out     (ex_alu_out),
        .zero        (ex_zero),
        .branch_addr (ex_branch_addr),
        .jump_addr   (ex_jump_addr),
        .wsel_out    (ex_wsel)
    );

    ex_mem_latch u_latch (
        .CLK             (CLK),
        .nRST            (nRST),
        .stall           (stall),
        .dren            (dren),
        .dwen            (dwen),
        .regwr           (regwr),
        .memtoreg        (memtoreg),
        .beq             (beq),
        .bne             (bne),
        .jump            (jump),
        .jr              (jr),
        .halt            (halt),
        .zero            (ex_zero),
        .alu_out         (ex_alu_out),
        .rdat1           (rdat1),
        .rdat2           (rdat2),
        .branch_addr     (ex_branch_addr),
        .jump_addr       (ex_jump_addr),
        .wsel            (ex_wsel),
        .dren_out        (mem_dren),
        .dwen_out        (mem_dwen),
        .regwr_out       (mem_regwr),
        .memtoreg_out    (mem_memtoreg),
        .beq_out         (mem_beq),
        .bne_out         (mem_bne),
        .jump_out        (mem_jump),
        .jr_out          (mem_jr),
        .halt_out        (mem_halt),
        .zero_out        (mem_zero),
        .alu_out_out     (mem_alu_out),
        .rdat1_out       (mem_rdat1),
        .rdat2_out       (mem_rdat2),
        .branch_addr_out (mem_branch_addr),
        .jump_addr_out   (mem_jump_addr),
        .wsel_out        (mem_wsel)
    );

    mem_stage u_mem (
        .dren          (mem_dren),
        .dwen          (mem_dwen),
        .regwr         (mem_regwr),
        .memtoreg      (mem_memtoreg),
        .beq           (mem_beq),
        .bne           (mem_bne),
        .jump          (mem_jump),
        .jr            (mem_jr),
        .zero          (mem_zero),
        .halt          (mem_halt),
        .alu_out       (mem_alu_out),
        .rdat1         (mem_rdat1),
        .rdat2         (mem_rdat2),
        .branch_addr   (mem_branch_addr),
        .jump_addr     (mem_jump_addr),
        .wsel          (mem_wsel),
        .dhit          (dhit),
        .ram_rdata     (ram_rdata),
        .ram_ren       (ram_ren),
        .ram_wen       (ram_wen),
        .ram_addr      (ram_addr),
        .ram_wdata     (ram_wdata),
        .stall         (stall),
        .wb_regwr      (wb_regwr),
        .wb_wsel       (wb_wsel),
        .wb_data       (wb_data),
        .redirect      (redirect),
        .redirect_addr (redirect_addr),
        .halt_out      (halt_out)
    );

    data_ram u_ram (
        .CLK   (CLK),
        .nRST  (nRST),
        .ren   (ram_ren),
        .wen   (ram_wen),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata),
        .dhit  (dhit)
    );

endmodule

//--- tests/exec_mem_checker.sv
// protocol assertions for exec_mem_top; assumes the RAM_WAIT hit timing of data_ram
module exec_mem_checker (
    input logic                 CLK,
    input logic                 nRST,
    input logic                 stall,
    input logic                 wb_regwr,
    input logic                 redirect,
    input cpu_types_pkg::word_t redirect_addr,
    input logic                 halt_out
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] stall_run;  // stall cycles before the current one
    int         fail_count = 0;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            stall_run <= '0;
        end else if (stall) begin
            stall_run <= stall_run + 8'd1;
        end else begin
            stall_run <= '0;
        end
    end

    // --------------------------------------------------
    // properties
    // --------------------------------------------------
    stall_bounded: assert property (@(posedge CLK) disable iff (!nRST)
        stall |-> (stall_run < 8'(cpu_types_pkg::RAM_WAIT + 1)))
        else begin
            fail_count++;
            $error("stall held longer than the memory latency");
        end

    // a finished stall covers the whole wait plus the hit cycle
    stall_exact: assert property (@(posedge CLK) disable iff (!nRST)
        $fell(stall) |-> (stall_run == 8'(cpu_types_pkg::RAM_WAIT + 1)))
        else begin
            fail_count++;
            $error("stall ended before the memory latency");
        end

    idle_after_reset: assert property (@(posedge CLK)
        $rose(nRST) |-> (!halt_out && !redirect && !stall))
        else begin
            fail_count++;
            $error("outputs active right after reset");
        end

    aligned_redirect: assert property (@(posedge CLK) disable iff (!nRST)
        redirect |-> (redirect_addr[1:0] == 2'b00))
        else begin
            fail_count++;
            $error("redirect target not word aligned");
        end

endmodule

bind exec_mem_top exec_mem_checker u_checker (
    .CLK           (CLK),
    .nRST          (nRST),
    .stall         (stall),
    .wb_regwr      (wb_regwr),
    .redirect      (redirect),
    .redirect_addr (redirect_addr),
    .halt_out      (halt_out)
);

//--- tests/exec_mem_monitor.sv
// compares top outputs at the falling edge; expects record() once per captured instruction
module exec_mem_monitor (
    input logic                    CLK,
    input logic                    nRST,
    input logic                    stall,
    input logic                    wb_regwr,
    input cpu_types_pkg::regbits_t wb_wsel,
    input cpu_types_pkg::word_t    wb_data,
    input logic                    redirect,
    input cpu_types_pkg::word_t    redirect_addr,
    input logic                    halt_out
);
    timeunit 1ns;
    timeprecision 100ps;

    int error_count = 0;
    int check_count = 0;
    int stall_run   = 0;
    int seq_no      = 0;

    string kind_name [12] = '{"alu_reg", "alu_imm", "lui", "store", "load", "beq",
                              "bne", "jump", "jr", "jal", "bubble", "halt"};

    cpu_types_pkg::word_t shadow [cpu_types_pkg::RAM_WORDS] = '{default: '0};

    // expected results, oldest first
    int                      q_kind   [$];
    logic                    q_regwr  [$];
    cpu_types_pkg::regbits_t q_wsel   [$];
    cpu_types_pkg::word_t    q_data   [$];
    logic                    q_redir  [$];
    cpu_types_pkg::word_t    q_raddr  [$];
    logic                    q_halt   [$];
    int                      q_stalls [$];

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic cpu_types_pkg::word_t ref_alu(input cpu_types_pkg::aluop_t op,
            input cpu_types_pkg::word_t a, input cpu_types_pkg::word_t b,
            input cpu_types_pkg::shamt_t sh);
        cpu_types_pkg::word_t fill;
        fill = ~(32'hffff_ffff >> sh);  // bits vacated by a right shift
        case (op)
            cpu_types_pkg::ALU_ADD:  return a + b;
            cpu_types_pkg::ALU_SUB:  return a + ~b + 32'd1;
            cpu_types_pkg::ALU_AND:  return a & b;
            cpu_types_pkg::ALU_OR:   return a | b;
            cpu_types_pkg::ALU_XOR:  return a ^ b;
            cpu_types_pkg::ALU_NOR:  return ~a & ~b;
            cpu_types_pkg::ALU_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            cpu_types_pkg::ALU_SLTU: return {31'd0, a < b};
            cpu_types_pkg::ALU_SLL:  return b << sh;
            cpu_types_pkg::ALU_SRL:  return b >> sh;
            cpu_types_pkg::ALU_SRA:  return (b >> sh) | (b[31] ? fill : 32'd0);
            default:                 return 32'd0;
        endcase
    endfunction

    task automatic record(input int kind, input logic regwr, input logic dren,
            input logic dwen, input logic beq, input logic bne, input logic jump,
            input logic jr, input logic jal, input logic lui, input logic alusrc,
            input logic halt, input cpu_types_pkg::aluop_t aluop,
            input cpu_types_pkg::word_t rdat1, input cpu_types_pkg::word_t rdat2,
            input cpu_types_pkg::word_t imm, input cpu_types_pkg::shamt_t shamt,
            input cpu_types_pkg::word_t pc4, input cpu_types_pkg::word_t j_addr,
            input cpu_types_pkg::regbits_t wsel);
        cpu_types_pkg::word_t data;
        cpu_types_pkg::word_t target;
        cpu_types_pkg::word_t addr;
        logic                 taken;
        addr = rdat1 + imm;
        data = ref_alu(aluop, rdat1, alusrc ? imm : rdat2, shamt);
        if (jal) data = pc4;
        else if (lui) data = {imm[15:0], 16'h0000};
        else if (dren) data = shadow[addr[9:2]];
        if (dwen) shadow[addr[9:2]] = rdat2;
        taken  = jr || jump || (beq && rdat1 == rdat2) || (bne && rdat1 != rdat2);
        target = pc4 + {imm[29:0], 2'b00};
        if (jump) target = {pc4[31:28], j_addr[25:0], 2'b00};
        if (jr) target = rdat1;
        q_kind.push_back(kind);
        q_regwr.push_back(regwr);
        q_wsel.push_back(jal ? 5'd31 : wsel);
        q_data.push_back(data);
        q_redir.push_back(taken);
        q_raddr.push_back(target);
        q_halt.push_back(halt);
        q_stalls.push_back((dren || dwen) ? int'(cpu_types_pkg::RAM_WAIT) + 1 : 0);
    endtask

    task automatic compare(input string name, input string field, input longint exp,
            input longint act);
        check_count++;
        if (exp != act) begin
            error_count++;
            $display("FAIL %s.%s #%0d: expected %h, actual %h", name, field, seq_no, exp, act);
        end
    endtask

    function automatic int pending();
        return q_kind.size();
    endfunction

    task automatic print_summary(input int assert_fails);
        $display("checks %0d, errors %0d, assertion failures %0d, unretired %0d",
                 check_count, error_count, assert_fails, pending());
    endtask

    // --------------------------------------------------
    // compare at the falling edge
    // --------------------------------------------------
    always @(negedge CLK) begin
        string name;
        if (nRST) begin
            if (stall) begin
                stall_run++;
                if (wb_regwr) begin
                    error_count++;
                    $display("ERROR: register write seen while the memory stalls");
                end
            end else if (q_kind.size() == 0) begin
                if (wb_regwr || redirect || halt_out) begin  // nothing in flight
                    error_count++;
                    $display("ERROR: outputs active with no instruction in flight");
                end
            end else begin
                name = kind_name[q_kind.pop_front()];
                compare(name, "stall_cycles", q_stalls.pop_front(), stall_run);
                compare(name, "wb_regwr", q_regwr[0], wb_regwr);
                if (q_regwr[0]) begin
                    compare(name, "wb_wsel", q_wsel[0], wb_wsel);
                    compare(name, "wb_data", q_data[0], wb_data);
                end
                compare(name, "redirect", q_redir[0], redirect);
                if (q_redir[0]) compare(name, "redirect_addr", q_raddr[0], redirect_addr);
                compare(name, "halt_out", q_halt.pop_front(), halt_out);
                void'(q_regwr.pop_front());
                void'(q_wsel.pop_front());
                void'(q_data.pop_front());
                void'(q_redir.pop_front());
                void'(q_raddr.pop_front());
                stall_run = 0;
                seq_no++;
            end
        end
    end

endmodule

//--- tests/exec_mem_tb.sv
// random instruction stream into exec_mem_top; one instruction in flight, held through stalls
module exec_mem_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_INSTR    = 400;
    localparam int TIMEOUT_NS = N_INSTR * (cpu_types_pkg::RAM_WAIT + 3) * 10 + 10 * 10 + 200;

    logic CLK;
    logic nRST;
    logic dren, dwen, regwr, memtoreg, beq, bne, jump, jr, jal, lui, alusrc, halt;
    cpu_types_pkg::aluop_t   aluop;
    cpu_types_pkg::word_t    rdat1, rdat2, ext_imm, pcplusfour, j_addr;
    cpu_types_pkg::shamt_t   shamt;
    cpu_types_pkg::regbits_t wsel;
    logic                    stall, wb_regwr, redirect, halt_out;
    cpu_types_pkg::regbits_t wb_wsel;
    cpu_types_pkg::word_t    wb_data, redirect_addr;
    int                      kind;

    exec_mem_top DUT (.*);

    exec_mem_monitor mon (.CLK(CLK), .nRST(nRST), .stall(stall), .wb_regwr(wb_regwr),
        .wb_wsel(wb_wsel), .wb_data(wb_data), .redirect(redirect),
        .redirect_addr(redirect_addr), .halt_out(halt_out));

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic clear_inputs();
        {dren, dwen, regwr, memtoreg, beq, bne, jump, jr, jal, lui, alusrc, halt} = '0;
        aluop = cpu_types_pkg::ALU_ADD;
        {rdat1, rdat2, ext_imm, pcplusfour, j_addr} = '0;
        shamt = '0;
        wsel  = '0;
    endtask

    // --------------------------------------------------
    // random instruction
    // --------------------------------------------------
    task automatic pick_instruction(input int k);
        logic [15:0] imm16;
        clear_inputs();
        kind       = k;
        imm16      = 16'($urandom);
        rdat1      = $urandom;
        rdat2      = $urandom;
        ext_imm    = {{16{imm16[15]}}, imm16};
        shamt      = 5'($urandom);
        pcplusfour = $urandom & 32'hffff_fffc;  // pc stays word aligned
        j_addr     = $urandom & 32'h03ff_ffff;
        wsel       = 5'($urandom);
        aluop      = cpu_types_pkg::aluop_t'($urandom_range(0, 10));
        case (k)
            0: regwr = 1'b1;
            1: {regwr, alusrc} = 2'b11;
            2: {regwr, lui} = 2'b11;
            3, 4: begin
                rdat1   = 32'($urandom_range(0, 23)) << 2;  // small range so words get reused
                ext_imm = 32'($urandom_range(0, 7)) << 2;
                aluop   = cpu_types_pkg::ALU_ADD;
                alusrc  = 1'b1;
                if (k == 3) dwen = 1'b1;
                else {dren, regwr, memtoreg} = 3'b111;
            end
            5, 6: begin
                aluop = cpu_types_pkg::ALU_SUB;
                if ($urandom_range(0, 1) == 1) rdat2 = rdat1;
                if (k == 5) beq = 1'b1;
                else bne = 1'b1;
            end
            7: jump = 1'b1;
            8: begin
                jr    = 1'b1;
                rdat1 = rdat1 & 32'hffff_fffc;
            end
            9: {jump, jal, regwr} = 3'b111;
            10: clear_inputs();
            default: halt = 1'b1;
        endcase
    endtask

    // present one instruction, then hand it to the monitor once it is captured
    task automatic issue(input int k);
        while (stall) begin
            @(posedge CLK);
            #1;
        end
        pick_instruction(k);
        @(posedge CLK);
        #1;
        mon.record(kind, regwr, dren, dwen, beq, bne, jump, jr, jal, lui, alusrc, halt,
                   aluop, rdat1, rdat2, ext_imm, shamt, pcplusfour, j_addr, wsel);
    endtask

    initial begin
        clear_inputs();
        kind = 10;
        nRST = 1'b0;
        void'($urandom(67));
        repeat (10) @(posedge CLK);
        #1 nRST = 1'b1;
        repeat (3) @(posedge CLK);  // idle outputs after reset
        #1;
        repeat (4) issue(10);
        issue(11);
        for (int i = 0; i < N_INSTR - 5; i++) begin
            issue($urandom_range(0, 11));
        end
        while (stall) begin
            @(posedge CLK);
            #1;
        end
        clear_inputs();
        repeat (4) @(posedge CLK);
        mon.print_summary(DUT.u_checker.fail_count);
        if (mon.error_count == 0 && mon.pending() == 0 && DUT.u_checker.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the instruction stream finished");
        $display("tests failed");
        $finish;
    end

endmodule

//--- all.f
verilog/cpu_types_pkg.sv
verilog/execute_stage.sv
verilog/ex_mem_latch.sv
verilog/mem_stage.sv
verilog/data_ram.sv
verilog/exec_mem_top.sv
tests/exec_mem_checker.sv
tests/exec_mem_monitor.sv
tests/exec_mem_tb.sv

//--- Makefile
# Verilator build for the ex/mem slice testbench

VERILATOR ?= verilator
TOP       ?= exec_mem_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) verilog/*.sv tests/*.sv
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
